//--- mini_mips.f
cpu_pkg.sv
cpu_regfile.sv
cpu_fetch.sv
cpu_decode.sv
cpu_execute.sv
cpu_result.sv
cpu_core.sv
tb_cpu_mem.sv
tb_cpu_core.sv

//--- Bender.yml
package:
  name: mini_mips

sources:
  - cpu_pkg.sv
  - cpu_regfile.sv
  - cpu_fetch.sv
  - cpu_decode.sv
  - cpu_execute.sv
  - cpu_result.sv
  - cpu_core.sv
  - target: simulation
    files:
      - tb_cpu_mem.sv
      - tb_cpu_core.sv

//--- tb_cpu_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_core;

	// random gaps and stalls at one in eight stay well inside this
	localparam int STALL_BUDGET = 128;
	localparam int DRAIN_CYCLES = 16;

	logic           clk;
	logic           rst;
	logic           ibus_read;
	logic           ibus_valid;
	logic           dbus_read;
	logic           dbus_write;
	logic           dbus_stall;
	cpu_pkg::word_t ibus_addr;
	cpu_pkg::word_t ibus_rdata;
	cpu_pkg::word_t dbus_addr;
	cpu_pkg::word_t dbus_wdata;
	cpu_pkg::word_t dbus_rdata;
	int             store_idx;
	int             cycles;
	int             limit;

	cpu_core u_dut (
		.clk          ( clk        ),
		.rst          ( rst        ),
		.ibus_read_o  ( ibus_read  ),
		.ibus_addr_o  ( ibus_addr  ),
		.ibus_rdata_i ( ibus_rdata ),
		.ibus_valid_i ( ibus_valid ),
		.dbus_read_o  ( dbus_read  ),
		.dbus_write_o ( dbus_write ),
		.dbus_addr_o  ( dbus_addr  ),
		.dbus_wdata_o ( dbus_wdata ),
		.dbus_rdata_i ( dbus_rdata ),
		.dbus_stall_i ( dbus_stall )
	);

	tb_cpu_mem u_mem (
		.clk          ( clk        ),
		.rst          ( rst        ),
		.ibus_read_i  ( ibus_read  ),
		.ibus_addr_i  ( ibus_addr  ),
		.ibus_rdata_o ( ibus_rdata ),
		.ibus_valid_o ( ibus_valid ),
		.dbus_read_i  ( dbus_read  ),
		.dbus_write_i ( dbus_write ),
		.dbus_addr_i  ( dbus_addr  ),
		.dbus_wdata_i ( dbus_wdata ),
		.dbus_rdata_o ( dbus_rdata ),
		.dbus_stall_o ( dbus_stall )
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_store(input string name, input cpu_pkg::word_t exp_val,
		input cpu_pkg::word_t act_val);
		if (act_val !== exp_val) begin
			$display("FAIL %s expected %h actual %h", name, exp_val, act_val);
			$display("Finished with errors");
			$fatal(1, "store mismatch");
		end
	endtask

	task automatic compare_flag(input string name, input logic exp_val, input logic act_val);
		if (act_val !== exp_val) begin
			$display("FAIL %s expected %b actual %b", name, exp_val, act_val);
			$display("Finished with errors");
			$fatal(1, "flag mismatch");
		end
	endtask

	// a store completes in a cycle with the write up and no stall
	always @(negedge clk) begin
		if (!rst && dbus_write && !dbus_stall) begin
			if (store_idx >= u_mem.exp_count) begin
				$display("extra store to %h with data %h after all expected stores",
					dbus_addr, dbus_wdata);
				$display("Finished with errors");
				$fatal(1, "unexpected store");
			end else begin
				check_store($sformatf("store %0d address", store_idx),
					u_mem.exp_addr[store_idx], dbus_addr);
				check_store($sformatf("store %0d data", store_idx),
					u_mem.exp_data[store_idx], dbus_wdata);
				store_idx++;
			end
		end
	end

	initial begin
		rst       = 1'b1;
		store_idx = 0;
		cycles    = 0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		// bus requests right after reset
		@(negedge clk);
		compare_flag("reset ibus read", 1'b1, ibus_read);
		compare_flag("reset dbus read", 1'b0, dbus_read);
		compare_flag("reset dbus write", 1'b0, dbus_write);
		limit = u_mem.instr_count * 3 + STALL_BUDGET;
		while (store_idx < u_mem.exp_count && cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		// core spins on the final self-branch and a stray store still gets caught
		repeat (DRAIN_CYCLES) @(posedge clk);
		if (store_idx == u_mem.exp_count) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			$display("timeout after %0d cycles, only %0d of %0d stores seen",
				cycles, store_idx, u_mem.exp_count);
			$display("Finished with errors");
			$fatal(1, "timeout");
		end
	end

endmodule

`default_nettype wire

//--- tb_cpu_mem.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_mem (
	input  logic           clk,
	input  logic           rst,
	input  logic           ibus_read_i,
	input  cpu_pkg::word_t ibus_addr_i,
	output cpu_pkg::word_t ibus_rdata_o,
	output logic           ibus_valid_o,
	input  logic           dbus_read_i,
	input  logic           dbus_write_i,
	input  cpu_pkg::word_t dbus_addr_i,
	input  cpu_pkg::word_t dbus_wdata_i,
	output cpu_pkg::word_t dbus_rdata_o,
	output logic           dbus_stall_o
);

	localparam int ROM_WORDS  = 64;
	localparam int RAM_WORDS  = 256;
	localparam int MAX_STORES = 32;
	localparam int MAX_STEPS  = 1000;

	cpu_pkg::word_t rom [ROM_WORDS];
	cpu_pkg::word_t ram [RAM_WORDS];
	int             rom_fill;

	// expected stores in program order, consumed by the checker
	cpu_pkg::word_t exp_addr [MAX_STORES];
	cpu_pkg::word_t exp_data [MAX_STORES];
	int             exp_count;
	int             instr_count;

	logic [31:0] lfsr_state;
	logic [7:0]  gap_bits;
	logic [7:0]  stall_bits;
	logic        gap_q;
	logic        stall_q;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		// taps 32 22 2 1
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output logic [7:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			bits[i]    = lfsr_state[0];
		end
	endtask

	function automatic cpu_pkg::word_t fill_word(input cpu_pkg::word_t addr);
		return addr ^ {addr[15:0], addr[31:16]} ^ 32'hc3a5_0f96;
	endfunction

	function automatic cpu_pkg::word_t enc_r(input logic [5:0] fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] sh);
		cpu_pkg::word_t w;
		w = '0;
		w[cpu_pkg::OPC_HI:cpu_pkg::OPC_LO]     = cpu_pkg::OPC_SPECIAL;
		w[cpu_pkg::RS_HI:cpu_pkg::RS_LO]       = rs;
		w[cpu_pkg::RT_HI:cpu_pkg::RT_LO]       = rt;
		w[cpu_pkg::RD_HI:cpu_pkg::RD_LO]       = rd;
		w[cpu_pkg::SHAMT_HI:cpu_pkg::SHAMT_LO] = sh;
		w[cpu_pkg::FUNCT_HI:cpu_pkg::FUNCT_LO] = fn;
		return w;
	endfunction

	function automatic cpu_pkg::word_t enc_i(input logic [5:0] opc, input logic [4:0] rt,
		input logic [4:0] rs, input int imm);
		cpu_pkg::word_t w;
		w = '0;
		w[cpu_pkg::OPC_HI:cpu_pkg::OPC_LO] = opc;
		w[cpu_pkg::RS_HI:cpu_pkg::RS_LO]   = rs;
		w[cpu_pkg::RT_HI:cpu_pkg::RT_LO]   = rt;
		w[cpu_pkg::IMM_HI:cpu_pkg::IMM_LO] = imm[15:0];
		return w;
	endfunction

	task automatic put_instr(input cpu_pkg::word_t w);
		rom[rom_fill] = w;
		rom_fill++;
	endtask

	// architectural model, one instruction per step
	function automatic int run_model();
		cpu_pkg::word_t r [32];
		cpu_pkg::word_t m [RAM_WORDS];
		cpu_pkg::word_t pc, ins, a, b, imm_s, imm_z, nxt, ea;
		logic [4:0]     rt, rd;
		int             steps;
		logic           done;
		for (int i = 0; i < 32; i++) begin
			r[i] = '0;
		end
		for (int i = 0; i < RAM_WORDS; i++) begin
			m[i] = fill_word(i * 4);
		end
		pc        = '0;
		steps     = 0;
		done      = 1'b0;
		exp_count = 0;
		while (!done && steps < MAX_STEPS) begin
			ins   = rom[pc[7:2]];
			a     = r[ins[cpu_pkg::RS_HI:cpu_pkg::RS_LO]];
			b     = r[ins[cpu_pkg::RT_HI:cpu_pkg::RT_LO]];
			rt    = ins[cpu_pkg::RT_HI:cpu_pkg::RT_LO];
			rd    = ins[cpu_pkg::RD_HI:cpu_pkg::RD_LO];
			imm_s = {{16{ins[15]}}, ins[15:0]};
			imm_z = {16'b0, ins[15:0]};
			ea    = a + imm_s;
			nxt   = pc + 32'd4;
			steps++;
			case (ins[cpu_pkg::OPC_HI:cpu_pkg::OPC_LO])
				cpu_pkg::OPC_SPECIAL: begin
					case (ins[cpu_pkg::FUNCT_HI:cpu_pkg::FUNCT_LO])
						cpu_pkg::FN_ADDU: r[rd] = a + b;
						cpu_pkg::FN_SUBU: r[rd] = a - b;
						cpu_pkg::FN_AND:  r[rd] = a & b;
						cpu_pkg::FN_OR:   r[rd] = a | b;
						cpu_pkg::FN_XOR:  r[rd] = a ^ b;
						cpu_pkg::FN_SLT:  r[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						cpu_pkg::FN_SLL:  r[rd] = b << ins[cpu_pkg::SHAMT_HI:cpu_pkg::SHAMT_LO];
						default: ;
					endcase
				end
				cpu_pkg::OPC_ADDIU: r[rt] = a + imm_s;
				cpu_pkg::OPC_ORI:   r[rt] = a | imm_z;
				cpu_pkg::OPC_LUI:   r[rt] = {ins[15:0], 16'b0};
				cpu_pkg::OPC_LW:    r[rt] = m[ea[9:2]];
				cpu_pkg::OPC_SW: begin
					m[ea[9:2]]          = b;
					exp_addr[exp_count] = ea;
					exp_data[exp_count] = b;
					exp_count++;
				end
				cpu_pkg::OPC_BEQ: if (a == b) nxt = pc + 32'd4 + (imm_s << 2);
				cpu_pkg::OPC_BNE: if (a != b) nxt = pc + 32'd4 + (imm_s << 2);
				default: ;
			endcase
			r[0] = '0;
			// a branch onto itself ends the program
			done = (nxt == pc);
			pc   = nxt;
		end
		return steps;
	endfunction

	initial begin
		lfsr_state = 32'h5e7e_a815;
		gap_q      = 1'b0;
		stall_q    = 1'b0;
		rom_fill   = 0;
		for (int i = 0; i < ROM_WORDS; i++) begin
			rom[i] = '0;
		end
		for (int i = 0; i < RAM_WORDS; i++) begin
			ram[i] = fill_word(i * 4);
		end
		// alu ops with back-to-back dependencies
		put_instr(enc_i(cpu_pkg::OPC_LUI, 1, 0, 'h1234));
		put_instr(enc_i(cpu_pkg::OPC_ORI, 1, 1, 'h5678));
		put_instr(enc_i(cpu_pkg::OPC_ADDIU, 2, 0, -3));
		put_instr(enc_i(cpu_pkg::OPC_ADDIU, 9, 0, 'h100));
		put_instr(enc_r(cpu_pkg::FN_ADDU, 3, 1, 2, 0));
		put_instr(enc_i(cpu_pkg::OPC_SW, 3, 9, 0));
		put_instr(enc_r(cpu_pkg::FN_SUBU, 4, 2, 1, 0));
		put_instr(enc_i(cpu_pkg::OPC_SW, 4, 9, 4));
		put_instr(enc_r(cpu_pkg::FN_AND, 5, 1, 4, 0));
		put_instr(enc_r(cpu_pkg::FN_OR, 6, 5, 2, 0));
		put_instr(enc_r(cpu_pkg::FN_XOR, 7, 6, 1, 0));
		put_instr(enc_i(cpu_pkg::OPC_SW, 7, 9, 8));
		put_instr(enc_r(cpu_pkg::FN_SLT, 8, 2, 1, 0));
		put_instr(enc_i(cpu_pkg::OPC_SW, 8, 9, 12));
		put_instr(enc_r(cpu_pkg::FN_SLL, 8, 0, 1, 4));
		put_instr(enc_i(cpu_pkg::OPC_SW, 8, 9, 16));
		put_instr(enc_i(cpu_pkg::OPC_SW, 5, 9, 20));
		put_instr(enc_i(cpu_pkg::OPC_SW, 6, 9, 24));
		// writes to r0 are lost
		put_instr(enc_i(cpu_pkg::OPC_ADDIU, 0, 0, 77));
		put_instr(enc_r(cpu_pkg::FN_ADDU, 0, 1, 1, 0));
		put_instr(enc_i(cpu_pkg::OPC_SW, 0, 9, 28));
		// loads, load-use and an untouched word
		put_instr(enc_i(cpu_pkg::OPC_LW, 10, 9, 4));
		put_instr(enc_r(cpu_pkg::FN_ADDU, 10, 10, 1, 0));
		put_instr(enc_i(cpu_pkg::OPC_SW, 10, 9, 32));
		put_instr(enc_i(cpu_pkg::OPC_LW, 11, 9, 'h40));
		put_instr(enc_i(cpu_pkg::OPC_SW, 11, 9, 36));
		put_instr(enc_i(cpu_pkg::OPC_LW, 12, 9, 16));
		put_instr(enc_i(cpu_pkg::OPC_SW, 12, 9, -4));
		// branches, not taken then taken
		put_instr(enc_i(cpu_pkg::OPC_BEQ, 2, 1, 1));
		put_instr(enc_i(cpu_pkg::OPC_SW, 1, 9, 40));
		put_instr(enc_i(cpu_pkg::OPC_BNE, 2, 1, 2));
		put_instr(enc_i(cpu_pkg::OPC_SW, 2, 9, 44));
		put_instr(enc_i(cpu_pkg::OPC_SW, 2, 9, 48));
		// count down loop
		put_instr(enc_i(cpu_pkg::OPC_ADDIU, 13, 0, 3));
		put_instr(enc_i(cpu_pkg::OPC_ADDIU, 13, 13, -1));
		put_instr(enc_i(cpu_pkg::OPC_SW, 13, 9, 52));
		put_instr(enc_i(cpu_pkg::OPC_BNE, 0, 13, -3));
		put_instr(enc_i(cpu_pkg::OPC_BEQ, 0, 13, 1));
		put_instr(enc_i(cpu_pkg::OPC_SW, 13, 9, 56));
		put_instr(enc_i(cpu_pkg::OPC_SW, 1, 9, 60));
		put_instr(enc_i(cpu_pkg::OPC_BEQ, 0, 0, -1));
		instr_count = run_model();
	end

	assign ibus_rdata_o = rom[ibus_addr_i[7:2]];
	assign ibus_valid_o = ibus_read_i && !gap_q;
	// load data only while a read is out
	assign dbus_rdata_o = dbus_read_i ? ram[dbus_addr_i[9:2]] : 'x;
	// back-pressure only while a request is out
	assign dbus_stall_o = stall_q && (dbus_read_i || dbus_write_i);

	always @(posedge clk) begin
		if (rst) begin
			gap_q   <= 1'b0;
			stall_q <= 1'b0;
		end else begin
			// about one cycle in eight each
			draw_bits(3, gap_bits);
			draw_bits(3, stall_bits);
			gap_q   <= &gap_bits[2:0];
			stall_q <= &stall_bits[2:0];
			if (dbus_write_i && !dbus_stall_o) begin
				ram[dbus_addr_i[9:2]] <= dbus_wdata_i;
			end
		end
	end

endmodule

`default_nettype wire

//--- cpu_core.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_core #(
	parameter cpu_pkg::word_t RESET_PC = '0
) (
	input  logic           clk,
	input  logic           rst,
	output logic           ibus_read_o,
	output cpu_pkg::word_t ibus_addr_o,
	input  cpu_pkg::word_t ibus_rdata_i,
	input  logic           ibus_valid_i,
	output logic           dbus_read_o,
	output logic           dbus_write_o,
	output cpu_pkg::word_t dbus_addr_o,
	output cpu_pkg::word_t dbus_wdata_o,
	input  cpu_pkg::word_t dbus_rdata_i,
	input  logic           dbus_stall_i
);

	logic               stall, branch_taken;
	cpu_pkg::word_t     branch_target;
	cpu_pkg::word_t     fd_instr, fd_pc;
	logic               fd_valid;
	cpu_pkg::reg_addr_t rf_raddr_a, rf_raddr_b, rf_waddr;
	cpu_pkg::word_t     rf_rdata_a, rf_rdata_b, rf_wdata;
	logic               rf_we;
	cpu_pkg::opcode_e   de_opcode, er_opcode;
	cpu_pkg::alu_op_e   de_alu_op;
	cpu_pkg::reg_addr_t de_rs, de_rt, de_rd, er_rd, fwd_addr;
	cpu_pkg::word_t     de_op_a, de_op_b, de_imm, de_pc;
	cpu_pkg::word_t     er_result, er_store_data, fwd_data;
	logic               de_valid, er_valid, fwd_valid;

	cpu_fetch #(
		.RESET_PC ( RESET_PC )
	) u_fetch (
		.clk, .rst,
		.stall_i         ( stall         ),
		.branch_taken_i  ( branch_taken  ),
		.branch_target_i ( branch_target ),
		.ibus_read_o, .ibus_addr_o, .ibus_rdata_i, .ibus_valid_i,
		.instr_o         ( fd_instr      ),
		.pc_o            ( fd_pc         ),
		.valid_o         ( fd_valid      )
	);

	cpu_regfile u_regfile (
		.clk, .rst,
		.raddr_a_i ( rf_raddr_a ), .raddr_b_i ( rf_raddr_b ),
		.rdata_a_o ( rf_rdata_a ), .rdata_b_o ( rf_rdata_b ),
		.we_i      ( rf_we      ), .waddr_i   ( rf_waddr   ), .wdata_i ( rf_wdata )
	);

	cpu_decode u_decode (
		.clk, .rst,
		.stall_i      ( stall      ), .flush_i      ( branch_taken ),
		.instr_i      ( fd_instr   ), .pc_i         ( fd_pc        ), .valid_i ( fd_valid ),
		.rf_raddr_a_o ( rf_raddr_a ), .rf_raddr_b_o ( rf_raddr_b   ),
		.rf_rdata_a_i ( rf_rdata_a ), .rf_rdata_b_i ( rf_rdata_b   ),
		.opcode_o     ( de_opcode  ), .alu_op_o     ( de_alu_op    ),
		.rs_o ( de_rs ), .rt_o ( de_rt ), .rd_o ( de_rd ),
		.op_a_o ( de_op_a ), .op_b_o ( de_op_b ), .imm_o ( de_imm ),
		.pc_o ( de_pc ), .valid_o ( de_valid )
	);

	cpu_execute u_execute (
		.clk, .rst,
		.stall_i  ( stall     ), .flush_i  ( branch_taken ),
		.opcode_i ( de_opcode ), .alu_op_i ( de_alu_op    ),
		.rs_i ( de_rs ), .rt_i ( de_rt ), .rd_i ( de_rd ),
		.op_a_i ( de_op_a ), .op_b_i ( de_op_b ), .imm_i ( de_imm ),
		.pc_i ( de_pc ), .valid_i ( de_valid ),
		.fwd_valid_i ( fwd_valid ), .fwd_addr_i ( fwd_addr ), .fwd_data_i ( fwd_data ),
		.branch_taken_o ( branch_taken ), .branch_target_o ( branch_target ),
		.opcode_o ( er_opcode ), .rd_o ( er_rd ), .result_o ( er_result ),
		.store_data_o ( er_store_data ), .valid_o ( er_valid )
	);

	cpu_result u_result (
		.clk, .rst,
		.opcode_i ( er_opcode ), .rd_i ( er_rd ), .result_i ( er_result ),
		.store_data_i ( er_store_data ), .valid_i ( er_valid ),
		.dbus_read_o, .dbus_write_o, .dbus_addr_o, .dbus_wdata_o,
		.dbus_rdata_i, .dbus_stall_i,
		.stall_o     ( stall     ),
		.rf_we_o     ( rf_we     ), .rf_waddr_o ( rf_waddr ), .rf_wdata_o ( rf_wdata ),
		.fwd_valid_o ( fwd_valid ), .fwd_addr_o ( fwd_addr ), .fwd_data_o ( fwd_data )
	);

endmodule

`default_nettype wire

//--- cpu_result.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_result (
	input  logic               clk,
	input  logic               rst,
	input  cpu_pkg::opcode_e   opcode_i,
	input  cpu_pkg::reg_addr_t rd_i,
	input  cpu_pkg::word_t     result_i,
	input  cpu_pkg::word_t     store_data_i,
	input  logic               valid_i,
	output logic               dbus_read_o,
	output logic               dbus_write_o,
	output cpu_pkg::word_t     dbus_addr_o,
	output cpu_pkg::word_t     dbus_wdata_o,
	input  cpu_pkg::word_t     dbus_rdata_i,
	input  logic               dbus_stall_i,
	output logic               stall_o,
	output logic               rf_we_o,
	output cpu_pkg::reg_addr_t rf_waddr_o,
	output cpu_pkg::word_t     rf_wdata_o,
	output logic               fwd_valid_o,
	output cpu_pkg::reg_addr_t fwd_addr_o,
	output cpu_pkg::word_t     fwd_data_o
);

	cpu_pkg::word_t wb_value;

	assign dbus_read_o  = valid_i && (opcode_i == cpu_pkg::OP_LW);
	assign dbus_write_o = valid_i && (opcode_i == cpu_pkg::OP_SW);
	assign dbus_addr_o  = result_i;
	assign dbus_wdata_o = store_data_i;
	assign stall_o      = dbus_stall_i;

	// load data is taken in the completing cycle
	assign wb_value = (opcode_i == cpu_pkg::OP_LW) ? dbus_rdata_i : result_i;

	assign rf_we_o    = valid_i && (rd_i != '0) && !dbus_stall_i;
	assign rf_waddr_o = rd_i;
	assign rf_wdata_o = wb_value;

	assign fwd_valid_o = valid_i && (rd_i != '0);
	assign fwd_addr_o  = rd_i;
	assign fwd_data_o  = wb_value;

	assert property (@(posedge clk) disable iff (rst)
		!(dbus_read_o && dbus_write_o));

	// stalled request has to wait with a frozen pipe behind it
	assert property (@(posedge clk) disable iff (rst)
		(dbus_read_o || dbus_write_o) && dbus_stall_i
		|=> (dbus_read_o || dbus_write_o) && $stable(dbus_addr_o));

endmodule

`default_nettype wire

//--- cpu_execute.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_execute (
	input  logic               clk,
	input  logic               rst,
	input  logic               stall_i,
	input  logic               flush_i,
	input  cpu_pkg::opcode_e   opcode_i,
	input  cpu_pkg::alu_op_e   alu_op_i,
	input  cpu_pkg::reg_addr_t rs_i,
	input  cpu_pkg::reg_addr_t rt_i,
	input  cpu_pkg::reg_addr_t rd_i,
	input  cpu_pkg::word_t     op_a_i,
	input  cpu_pkg::word_t     op_b_i,
	input  cpu_pkg::word_t     imm_i,
	input  cpu_pkg::word_t     pc_i,
	input  logic               valid_i,
	input  logic               fwd_valid_i,
	input  cpu_pkg::reg_addr_t fwd_addr_i,
	input  cpu_pkg::word_t     fwd_data_i,
	output logic               branch_taken_o,
	output cpu_pkg::word_t     branch_target_o,
	output cpu_pkg::opcode_e   opcode_o,
	output cpu_pkg::reg_addr_t rd_o,
	output cpu_pkg::word_t     result_o,
	output cpu_pkg::word_t     store_data_o,
	output logic               valid_o
);

	cpu_pkg::word_t opnd_a, opnd_b, src_b, alu_res;
	logic           is_eq;

	// bypass from the instruction one ahead in result
	assign opnd_a = (fwd_valid_i && fwd_addr_i == rs_i && rs_i != '0) ? fwd_data_i : op_a_i;
	assign opnd_b = (fwd_valid_i && fwd_addr_i == rt_i && rt_i != '0) ? fwd_data_i : op_b_i;
	assign src_b  = (opcode_i == cpu_pkg::OP_ALU_R) ? opnd_b : imm_i;

	// loads and stores take their address from the add path
	always_comb begin
		case (alu_op_i)
			cpu_pkg::ALU_ADD: alu_res = opnd_a + src_b;
			cpu_pkg::ALU_SUB: alu_res = opnd_a - src_b;
			cpu_pkg::ALU_AND: alu_res = opnd_a & src_b;
			cpu_pkg::ALU_OR:  alu_res = opnd_a | src_b;
			cpu_pkg::ALU_XOR: alu_res = opnd_a ^ src_b;
			cpu_pkg::ALU_SLT: alu_res = {31'b0, $signed(opnd_a) < $signed(src_b)};
			cpu_pkg::ALU_SLL: alu_res = opnd_b << imm_i[4:0];
			cpu_pkg::ALU_LUI: alu_res = {imm_i[15:0], 16'b0};
			default:          alu_res = '0;
		endcase
	end

	assign is_eq = (opnd_a == opnd_b);
	assign branch_taken_o = valid_i &&
		((opcode_i == cpu_pkg::OP_BEQ && is_eq) || (opcode_i == cpu_pkg::OP_BNE && !is_eq));
	assign branch_target_o = pc_i + 32'd4 + {imm_i[29:0], 2'b00};

	// a taken branch leaves a bubble behind it
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_o <= 1'b0;
		end else if (!stall_i) begin
			valid_o <= valid_i && !flush_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i) begin
			opcode_o     <= opcode_i;
			rd_o         <= rd_i;
			result_o     <= alu_res;
			store_data_o <= opnd_b;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		$rose(branch_taken_o) |-> valid_i &&
		(opcode_i inside {cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE}));

	// decode was flushed on the redirect edge
	assert property (@(posedge clk) disable iff (rst)
		branch_taken_o && !stall_i |=> !valid_i);

endmodule

`default_nettype wire

//--- cpu_decode.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_decode (
	input  logic               clk,
	input  logic               rst,
	input  logic               stall_i,
	input  logic               flush_i,
	input  cpu_pkg::word_t     instr_i,
	input  cpu_pkg::word_t     pc_i,
	input  logic               valid_i,
	output cpu_pkg::reg_addr_t rf_raddr_a_o,
	output cpu_pkg::reg_addr_t rf_raddr_b_o,
	input  cpu_pkg::word_t     rf_rdata_a_i,
	input  cpu_pkg::word_t     rf_rdata_b_i,
	output cpu_pkg::opcode_e   opcode_o,
	output cpu_pkg::alu_op_e   alu_op_o,
	output cpu_pkg::reg_addr_t rs_o,
	output cpu_pkg::reg_addr_t rt_o,
	output cpu_pkg::reg_addr_t rd_o,
	output cpu_pkg::word_t     op_a_o,
	output cpu_pkg::word_t     op_b_o,
	output cpu_pkg::word_t     imm_o,
	output cpu_pkg::word_t     pc_o,
	output logic               valid_o
);

	logic [cpu_pkg::OPC_W-1:0]   opc;
	logic [cpu_pkg::FUNCT_W-1:0] funct;
	cpu_pkg::reg_addr_t          rs, rt, rd;
	cpu_pkg::word_t              imm_sext, imm_zext, shamt_zext;
	cpu_pkg::opcode_e            opcode_d;
	cpu_pkg::alu_op_e            alu_op_d;
	cpu_pkg::reg_addr_t          dest_d;
	cpu_pkg::word_t              imm_d;

	assign opc   = instr_i[cpu_pkg::OPC_HI:cpu_pkg::OPC_LO];
	assign funct = instr_i[cpu_pkg::FUNCT_HI:cpu_pkg::FUNCT_LO];
	assign rs    = instr_i[cpu_pkg::RS_HI:cpu_pkg::RS_LO];
	assign rt    = instr_i[cpu_pkg::RT_HI:cpu_pkg::RT_LO];
	assign rd    = instr_i[cpu_pkg::RD_HI:cpu_pkg::RD_LO];

	assign imm_sext = {{(cpu_pkg::WORD_W-cpu_pkg::IMM_W){instr_i[cpu_pkg::IMM_HI]}},
		instr_i[cpu_pkg::IMM_HI:cpu_pkg::IMM_LO]};
	assign imm_zext = {{(cpu_pkg::WORD_W-cpu_pkg::IMM_W){1'b0}},
		instr_i[cpu_pkg::IMM_HI:cpu_pkg::IMM_LO]};
	assign shamt_zext = {{(cpu_pkg::WORD_W-cpu_pkg::SHAMT_W){1'b0}},
		instr_i[cpu_pkg::SHAMT_HI:cpu_pkg::SHAMT_LO]};

	assign rf_raddr_a_o = rs;
	assign rf_raddr_b_o = rt;

	always_comb begin
		opcode_d = cpu_pkg::OP_NOP;
		alu_op_d = cpu_pkg::ALU_ADD;
		dest_d   = '0;
		imm_d    = imm_sext;
		case (opc)
			cpu_pkg::OPC_SPECIAL: begin
				opcode_d = cpu_pkg::OP_ALU_R;
				dest_d   = rd;
				imm_d    = shamt_zext;
				case (funct)
					cpu_pkg::FN_ADDU: alu_op_d = cpu_pkg::ALU_ADD;
					cpu_pkg::FN_SUBU: alu_op_d = cpu_pkg::ALU_SUB;
					cpu_pkg::FN_AND:  alu_op_d = cpu_pkg::ALU_AND;
					cpu_pkg::FN_OR:   alu_op_d = cpu_pkg::ALU_OR;
					cpu_pkg::FN_XOR:  alu_op_d = cpu_pkg::ALU_XOR;
					cpu_pkg::FN_SLT:  alu_op_d = cpu_pkg::ALU_SLT;
					cpu_pkg::FN_SLL:  alu_op_d = cpu_pkg::ALU_SLL;
					default: begin
						opcode_d = cpu_pkg::OP_NOP;
						dest_d   = '0;
					end
				endcase
			end
			cpu_pkg::OPC_ADDIU: begin
				opcode_d = cpu_pkg::OP_ADDIU;
				dest_d   = rt;
			end
			cpu_pkg::OPC_ORI: begin
				opcode_d = cpu_pkg::OP_ORI;
				alu_op_d = cpu_pkg::ALU_OR;
				dest_d   = rt;
				imm_d    = imm_zext;
			end
			cpu_pkg::OPC_LUI: begin
				opcode_d = cpu_pkg::OP_LUI;
				alu_op_d = cpu_pkg::ALU_LUI;
				dest_d   = rt;
				imm_d    = imm_zext;
			end
			cpu_pkg::OPC_LW: begin
				opcode_d = cpu_pkg::OP_LW;
				dest_d   = rt;
			end
			cpu_pkg::OPC_SW:  opcode_d = cpu_pkg::OP_SW;
			cpu_pkg::OPC_BEQ: opcode_d = cpu_pkg::OP_BEQ;
			cpu_pkg::OPC_BNE: opcode_d = cpu_pkg::OP_BNE;
			default: opcode_d = cpu_pkg::OP_NOP;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_o <= 1'b0;
		end else if (!stall_i) begin
			valid_o <= valid_i && !flush_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i) begin
			opcode_o <= opcode_d;
			alu_op_o <= alu_op_d;
			rs_o     <= rs;
			rt_o     <= rt;
			rd_o     <= dest_d;
			op_a_o   <= rf_rdata_a_i;
			op_b_o   <= rf_rdata_b_i;
			imm_o    <= imm_d;
			pc_o     <= pc_i;
		end
	end

	// stores and branches must never reach result with a destination
	assert property (@(posedge clk) disable iff (rst)
		valid_o && (opcode_o inside {cpu_pkg::OP_SW, cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE})
		|-> rd_o == '0);

endmodule

`default_nettype wire

//--- cpu_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_fetch #(
	parameter cpu_pkg::word_t RESET_PC = '0
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           stall_i,
	input  logic           branch_taken_i,
	input  cpu_pkg::word_t branch_target_i,
	output logic           ibus_read_o,
	output cpu_pkg::word_t ibus_addr_o,
	input  cpu_pkg::word_t ibus_rdata_i,
	input  logic           ibus_valid_i,
	output cpu_pkg::word_t instr_o,
	output cpu_pkg::word_t pc_o,
	output logic           valid_o
);

	cpu_pkg::word_t pc_q;

	assign ibus_read_o = ~stall_i;
	assign ibus_addr_o = pc_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q    <= RESET_PC;
			valid_o <= 1'b0;
		end else if (!stall_i) begin
			if (branch_taken_i) begin
				pc_q <= branch_target_i;
			end else if (ibus_valid_i) begin
				pc_q <= pc_q + 32'd4;
			end
			// word in flight on a redirect is dropped
			valid_o <= ibus_valid_i && !branch_taken_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i && ibus_valid_i) begin
			instr_o <= ibus_rdata_i;
			pc_o    <= pc_q;
		end
	end

endmodule

`default_nettype wire

//--- cpu_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_regfile (
	input  logic              clk,
	input  logic              rst,
	input  cpu_pkg::reg_addr_t raddr_a_i,
	input  cpu_pkg::reg_addr_t raddr_b_i,
	output cpu_pkg::word_t     rdata_a_o,
	output cpu_pkg::word_t     rdata_b_o,
	input  logic              we_i,
	input  cpu_pkg::reg_addr_t waddr_i,
	input  cpu_pkg::word_t     wdata_i
);

	cpu_pkg::word_t regs [1:31];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && waddr_i != '0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// write-through, a read of the register being written sees the new value
	assign rdata_a_o = (raddr_a_i == '0) ? '0 :
		(we_i && waddr_i == raddr_a_i) ? wdata_i : regs[raddr_a_i];
	assign rdata_b_o = (raddr_b_i == '0) ? '0 :
		(we_i && waddr_i == raddr_b_i) ? wdata_i : regs[raddr_b_i];

endmodule

`default_nettype wire

//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int WORD_W  = 32;
	localparam int OPC_W   = 6;
	localparam int REG_W   = 5;
	localparam int SHAMT_W = 5;
	localparam int FUNCT_W = 6;
	localparam int IMM_W   = 16;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_W-1:0]  reg_addr_t;

	// instruction field positions
	localparam int OPC_HI   = 31;
	localparam int OPC_LO   = 26;
	localparam int RS_HI    = 25;
	localparam int RS_LO    = 21;
	localparam int RT_HI    = 20;
	localparam int RT_LO    = 16;
	localparam int RD_HI    = 15;
	localparam int RD_LO    = 11;
	localparam int SHAMT_HI = 10;
	localparam int SHAMT_LO = 6;
	localparam int FUNCT_HI = 5;
	localparam int FUNCT_LO = 0;
	localparam int IMM_HI   = 15;
	localparam int IMM_LO   = 0;

	// primary opcodes
	localparam logic [OPC_W-1:0] OPC_SPECIAL = 6'h00;
	localparam logic [OPC_W-1:0] OPC_BEQ     = 6'h04;
	localparam logic [OPC_W-1:0] OPC_BNE     = 6'h05;
	localparam logic [OPC_W-1:0] OPC_ADDIU   = 6'h09;
	localparam logic [OPC_W-1:0] OPC_ORI     = 6'h0d;
	localparam logic [OPC_W-1:0] OPC_LUI     = 6'h0f;
	localparam logic [OPC_W-1:0] OPC_LW      = 6'h23;
	localparam logic [OPC_W-1:0] OPC_SW      = 6'h2b;

	// funct codes under SPECIAL
	localparam logic [FUNCT_W-1:0] FN_SLL  = 6'h00;
	localparam logic [FUNCT_W-1:0] FN_ADDU = 6'h21;
	localparam logic [FUNCT_W-1:0] FN_SUBU = 6'h23;
	localparam logic [FUNCT_W-1:0] FN_AND  = 6'h24;
	localparam logic [FUNCT_W-1:0] FN_OR   = 6'h25;
	localparam logic [FUNCT_W-1:0] FN_XOR  = 6'h26;
	localparam logic [FUNCT_W-1:0] FN_SLT  = 6'h2a;

	typedef enum logic [3:0] {
		OP_NOP, OP_ALU_R, OP_ADDIU, OP_ORI, OP_LUI, OP_LW, OP_SW, OP_BEQ, OP_BNE
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_LUI
	} alu_op_e;

endpackage

`default_nettype wire
